//--- hw/ncpu_core.sv
// Core slice top joining decoder, register file and execution unit
`default_nettype none

module ncpu_core #(
   parameter int DW = 32,
   parameter int AW = 32
) (
   input  wire                 clk,
   input  wire                 arst_n_i,
   input  wire                 insn_valid_i,
   output logic                insn_ready_o,
   input  ncpu_pkg::insn_t     insn_i,
   input  wire  [AW-3:0]       insn_pc_i,
   output logic                res_valid_o,
   input  wire                 res_ready_i,
   output logic [AW-3:0]       res_pc_o,
   output logic                res_wb_o,
   output ncpu_pkg::reg_addr_t res_addr_o,
   output logic [DW-1:0]       res_data_o,
   output logic                res_emu_o
);

   import ncpu_pkg::*;

   // Register file requests and responses
   logic          rs1_re;
   reg_addr_t     rs1_addr;
   logic          rs2_re;
   reg_addr_t     rs2_addr;
   logic [DW-1:0] rs1_data;
   logic          rs1_valid;
   logic [DW-1:0] rs2_data;
   logic          rs2_valid;

   // Decoded operation
   logic          op_valid;
   logic          op_ready;
   lu_op_t        lu_op;
   au_op_t        au_op;
   logic          emu;
   logic          wb;
   reg_addr_t     wb_addr;
   logic [DW-1:0] operand_1;
   logic [DW-1:0] operand_2;
   logic [AW-3:0] pc;

   // Writeback
   logic          we;
   reg_addr_t     waddr;
   logic [DW-1:0] wdata;

   ncpu_idu #(.DW(DW), .AW(AW)) idu_i (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_valid_i  (insn_valid_i),
      .in_ready_o  (insn_ready_o),
      .insn_i      (insn_i),
      .insn_pc_i   (insn_pc_i),
      .rs1_re_o    (rs1_re),
      .rs1_addr_o  (rs1_addr),
      .rs2_re_o    (rs2_re),
      .rs2_addr_o  (rs2_addr),
      .rs1_data_i  (rs1_data),
      .rs1_valid_i (rs1_valid),
      .rs2_data_i  (rs2_data),
      .rs2_valid_i (rs2_valid),
      .op_valid_o  (op_valid),
      .op_ready_i  (op_ready),
      .lu_op_o     (lu_op),
      .au_op_o     (au_op),
      .emu_o       (emu),
      .wb_o        (wb),
      .wb_addr_o   (wb_addr),
      .operand_1_o (operand_1),
      .operand_2_o (operand_2),
      .pc_o        (pc)
   );

   ncpu_regfile #(.DW(DW)) regfile_i (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .rs1_re_i    (rs1_re),
      .rs1_addr_i  (rs1_addr),
      .rs2_re_i    (rs2_re),
      .rs2_addr_i  (rs2_addr),
      .rs1_data_o  (rs1_data),
      .rs2_data_o  (rs2_data),
      .rs1_valid_o (rs1_valid),
      .rs2_valid_o (rs2_valid),
      .we_i        (we),
      .waddr_i     (waddr),
      .wdata_i     (wdata)
   );

   ncpu_ieu #(.DW(DW), .AW(AW)) ieu_i (
      .op_valid_i  (op_valid),
      .op_ready_o  (op_ready),
      .lu_op_i     (lu_op),
      .au_op_i     (au_op),
      .emu_i       (emu),
      .wb_i        (wb),
      .wb_addr_i   (wb_addr),
      .operand_1_i (operand_1),
      .operand_2_i (operand_2),
      .pc_i        (pc),
      .res_valid_o (res_valid_o),
      .res_ready_i (res_ready_i),
      .res_pc_o    (res_pc_o),
      .res_wb_o    (res_wb_o),
      .res_addr_o  (res_addr_o),
      .res_data_o  (res_data_o),
      .res_emu_o   (res_emu_o),
      .we_o        (we),
      .waddr_o     (waddr),
      .wdata_o     (wdata)
   );

endmodule

`default_nettype wire

//--- hw/ncpu_idu.sv
// Instruction decoder that reads source registers and buffers the decoded operation
`default_nettype none

module ncpu_idu #(
   parameter int DW = 32,
   parameter int AW = 32
) (
   input  wire                 clk,
   input  wire                 arst_n_i,
   input  wire                 in_valid_i,
   output logic                in_ready_o,
   input  ncpu_pkg::insn_t     insn_i,
   input  wire  [AW-3:0]       insn_pc_i,
   output logic                rs1_re_o,
   output ncpu_pkg::reg_addr_t rs1_addr_o,
   output logic                rs2_re_o,
   output ncpu_pkg::reg_addr_t rs2_addr_o,
   input  wire  [DW-1:0]       rs1_data_i,
   input  wire                 rs1_valid_i,
   input  wire  [DW-1:0]       rs2_data_i,
   input  wire                 rs2_valid_i,
   output logic                op_valid_o,
   input  wire                 op_ready_i,
   output ncpu_pkg::lu_op_t    lu_op_o,
   output ncpu_pkg::au_op_t    au_op_o,
   output logic                emu_o,
   output logic                wb_o,
   output ncpu_pkg::reg_addr_t wb_addr_o,
   output logic [DW-1:0]       operand_1_o,
   output logic [DW-1:0]       operand_2_o,
   output logic [AW-3:0]       pc_o
);

   import ncpu_pkg::*;

   opcode_e              opc;
   logic [IMM14_W-1:0]   f_imm14;
   logic [IMM18_W-1:0]   f_imm18;
   lu_op_t               lu_op;
   au_op_t               au_op;
   logic                 use_imm14;
   logic                 use_imm18;
   logic                 imm_signed;
   logic                 emu;
   logic                 wb;
   logic                 rs1_need;
   logic                 rs2_need;
   logic [DW-1:0]        imm;
   logic                 cas;

   logic [DW-1:0]        imm_q;
   logic                 rs1_rd_q;
   logic                 rs2_rd_q;

   assign opc     = opcode_e'(insn_i[OPC_MSB:OPC_LSB]);
   assign f_imm14 = insn_i[IMM14_MSB:IMM14_LSB];
   assign f_imm18 = insn_i[IMM18_MSB:IMM18_LSB];

   always_comb begin
      lu_op      = '0;
      au_op      = '0;
      use_imm14  = 1'b0;
      use_imm18  = 1'b0;
      imm_signed = 1'b0;
      case (opc)
         OP_AND:   lu_op[LU_AND] = 1'b1;
         OP_OR:    lu_op[LU_OR]  = 1'b1;
         OP_XOR:   lu_op[LU_XOR] = 1'b1;
         OP_LSL:   lu_op[LU_LSL] = 1'b1;
         OP_LSR:   lu_op[LU_LSR] = 1'b1;
         OP_ADD:   au_op[AU_ADD] = 1'b1;
         OP_SUB:   au_op[AU_SUB] = 1'b1;
         OP_CMP:   au_op[AU_CMP] = 1'b1;
         OP_AND_I: begin
            lu_op[LU_AND] = 1'b1;
            use_imm14     = 1'b1;
            imm_signed    = 1'b1;
         end
         OP_OR_I: begin
            lu_op[LU_OR] = 1'b1;
            use_imm14    = 1'b1;
         end
         OP_XOR_I: begin
            lu_op[LU_XOR] = 1'b1;
            use_imm14     = 1'b1;
            imm_signed    = 1'b1;
         end
         OP_LSL_I: begin
            lu_op[LU_LSL] = 1'b1;
            use_imm14     = 1'b1;
         end
         OP_LSR_I: begin
            lu_op[LU_LSR] = 1'b1;
            use_imm14     = 1'b1;
         end
         OP_ADD_I: begin
            au_op[AU_ADD] = 1'b1;
            use_imm14     = 1'b1;
            imm_signed    = 1'b1;
         end
         OP_MHI: begin
            au_op[AU_MHI] = 1'b1;
            use_imm18     = 1'b1;
         end
         default: ;
      endcase
   end

   // Nothing selected means the opcode is left to software
   assign emu      = ~(|lu_op | |au_op);
   assign wb       = ~(au_op[AU_CMP] | emu);
   assign rs1_need = ~use_imm18;
   assign rs2_need = ~(use_imm14 | use_imm18);

   assign imm = use_imm18  ? ({{(DW-IMM18_W){1'b0}}, f_imm18} << MHI_SHIFT) :
                imm_signed ? {{(DW-IMM14_W){f_imm14[IMM14_W-1]}}, f_imm14} :
                             {{(DW-IMM14_W){1'b0}}, f_imm14};

   ncpu_pipe_buf pipe_buf_i (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_valid_o (op_valid_o),
      .out_ready_i (op_ready_i),
      .cas_o       (cas)
   );

   // Register reads are issued only for the word being captured
   assign rs1_re_o   = cas & rs1_need;
   assign rs1_addr_o = insn_i[RS1_LSB +: REG_AW];
   assign rs2_re_o   = cas & rs2_need;
   assign rs2_addr_o = insn_i[RS2_LSB +: REG_AW];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lu_op_o  <= '0;
         au_op_o  <= '0;
         emu_o    <= 1'b0;
         wb_o     <= 1'b0;
         rs1_rd_q <= 1'b0;
         rs2_rd_q <= 1'b0;
      end else if (cas) begin
         lu_op_o  <= lu_op;
         au_op_o  <= au_op;
         emu_o    <= emu;
         wb_o     <= wb;
         rs1_rd_q <= rs1_need;
         rs2_rd_q <= rs2_need;
      end
   end

   always_ff @(posedge clk) begin
      if (cas) begin
         imm_q     <= imm;
         pc_o      <= insn_pc_i;
         wb_addr_o <= insn_i[RD_LSB +: REG_AW];
      end
   end

   assign operand_1_o = (rs1_rd_q & rs1_valid_i) ? rs1_data_i : imm_q;
   assign operand_2_o = (rs2_rd_q & rs2_valid_i) ? rs2_data_i : imm_q;

endmodule

`default_nettype wire

//--- hw/ncpu_ieu.sv
// Integer execution unit for logic, shift, add/sub, compare and move-high
`default_nettype none

module ncpu_ieu #(
   parameter int DW = 32,
   parameter int AW = 32
) (
   input  wire                 op_valid_i,
   output logic                op_ready_o,
   input  ncpu_pkg::lu_op_t    lu_op_i,
   input  ncpu_pkg::au_op_t    au_op_i,
   input  wire                 emu_i,
   input  wire                 wb_i,
   input  ncpu_pkg::reg_addr_t wb_addr_i,
   input  wire  [DW-1:0]       operand_1_i,
   input  wire  [DW-1:0]       operand_2_i,
   input  wire  [AW-3:0]       pc_i,
   output logic                res_valid_o,
   input  wire                 res_ready_i,
   output logic [AW-3:0]       res_pc_o,
   output logic                res_wb_o,
   output ncpu_pkg::reg_addr_t res_addr_o,
   output logic [DW-1:0]       res_data_o,
   output logic                res_emu_o,
   output logic                we_o,
   output ncpu_pkg::reg_addr_t waddr_o,
   output logic [DW-1:0]       wdata_o
);

   import ncpu_pkg::*;

   localparam int SHW = $clog2(DW);

   logic [SHW-1:0] shamt;
   logic [DW-1:0]  lu_and;
   logic [DW-1:0]  lu_or;
   logic [DW-1:0]  lu_xor;
   logic [DW-1:0]  lu_lsl;
   logic [DW-1:0]  lu_lsr;
   logic [DW-1:0]  add_b;
   logic [DW-1:0]  au_sum;
   logic [DW-1:0]  au_cmp;
   logic [DW-1:0]  result;

   assign shamt  = operand_2_i[SHW-1:0];

   assign lu_and = operand_1_i & operand_2_i;
   assign lu_or  = operand_1_i | operand_2_i;
   assign lu_xor = operand_1_i ^ operand_2_i;
   assign lu_lsl = operand_1_i << shamt;
   assign lu_lsr = operand_1_i >> shamt;

   // One adder for both add and subtract
   assign add_b  = au_op_i[AU_SUB] ? ~operand_2_i : operand_2_i;
   assign au_sum = operand_1_i + add_b + {{(DW-1){1'b0}}, au_op_i[AU_SUB]};

   // Equality flag in bit 0
   assign au_cmp = {{(DW-1){1'b0}}, operand_1_i == operand_2_i};

   // Selectors are one-hot, so an and-or mux is enough
   // Emulated ops have no selector set and give zero
   assign result = ({DW{lu_op_i[LU_AND]}} & lu_and) |
                   ({DW{lu_op_i[LU_OR]}}  & lu_or)  |
                   ({DW{lu_op_i[LU_XOR]}} & lu_xor) |
                   ({DW{lu_op_i[LU_LSL]}} & lu_lsl) |
                   ({DW{lu_op_i[LU_LSR]}} & lu_lsr) |
                   ({DW{au_op_i[AU_ADD] | au_op_i[AU_SUB]}} & au_sum) |
                   ({DW{au_op_i[AU_CMP]}} & au_cmp) |
                   ({DW{au_op_i[AU_MHI]}} & operand_2_i);

   // Handshake passes straight through
   assign res_valid_o = op_valid_i;
   assign op_ready_o  = res_ready_i;

   assign res_pc_o    = pc_i;
   assign res_wb_o    = wb_i;
   assign res_addr_o  = wb_addr_i;
   assign res_data_o  = result;
   assign res_emu_o   = emu_i;

   // Write back only when the result is taken
   assign we_o    = op_valid_i & res_ready_i & wb_i;
   assign waddr_o = wb_addr_i;
   assign wdata_o = result;

endmodule

`default_nettype wire

//--- hw/ncpu_pipe_buf.sv
// Pipeline buffer holding one item between a valid/ready producer and consumer
`default_nettype none

module ncpu_pipe_buf (
   input  wire  clk,
   input  wire  arst_n_i,
   input  wire  in_valid_i,
   output logic in_ready_o,
   output logic out_valid_o,
   input  wire  out_ready_i,
   output logic cas_o
);

   logic full_q;

   // Room when empty, or when the held item leaves this cycle
   assign in_ready_o = ~full_q | out_ready_i;

   // Capture strobe for the payload registers of the producer
   assign cas_o = in_valid_i & in_ready_o;

   assign out_valid_o = full_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         full_q <= 1'b0;
      end else if (cas_o) begin
         full_q <= 1'b1;
      end else if (out_ready_i) begin
         // Drained with nothing new behind it
         full_q <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- hw/ncpu_pkg.sv
// Core package with opcode encoding, field positions and shared vector types
`default_nettype none

package ncpu_pkg;

   // Register file geometry
   localparam int REG_AW   = 5;
   localparam int NUM_REGS = 32;

   // Instruction field positions
   localparam int OPC_LSB   = 0;
   localparam int OPC_MSB   = 5;
   localparam int RD_LSB    = 6;
   localparam int RD_MSB    = 11;
   localparam int RS1_LSB   = 12;
   localparam int RS1_MSB   = 17;
   localparam int RS2_LSB   = 18;
   localparam int RS2_MSB   = 23;
   localparam int IMM14_LSB = 18;
   localparam int IMM14_MSB = 31;
   localparam int IMM18_LSB = 12;
   localparam int IMM18_MSB = 29;

   localparam int IMM14_W   = 14;
   localparam int IMM18_W   = 18;
   // Move-high places imm18 at this bit and above
   localparam int MHI_SHIFT = 14;

   typedef logic [31:0]       insn_t;
   typedef logic [REG_AW-1:0] reg_addr_t;

   // Logic unit one-hot selector bits
   localparam int LU_AND = 0;
   localparam int LU_OR  = 1;
   localparam int LU_XOR = 2;
   localparam int LU_LSL = 3;
   localparam int LU_LSR = 4;
   typedef logic [4:0] lu_op_t;

   // Arithmetic unit one-hot selector bits
   localparam int AU_ADD = 0;
   localparam int AU_SUB = 1;
   localparam int AU_CMP = 2;
   localparam int AU_MHI = 3;
   typedef logic [3:0] au_op_t;

   // Executed opcodes, any other code goes to emulation
   typedef enum logic [5:0] {
      OP_AND   = 6'h01,
      OP_AND_I = 6'h02,
      OP_OR    = 6'h03,
      OP_OR_I  = 6'h04,
      OP_XOR   = 6'h05,
      OP_XOR_I = 6'h06,
      OP_LSL   = 6'h07,
      OP_LSL_I = 6'h08,
      OP_LSR   = 6'h09,
      OP_LSR_I = 6'h0a,
      OP_ADD   = 6'h0b,
      OP_ADD_I = 6'h0c,
      OP_SUB   = 6'h0d,
      OP_CMP   = 6'h0e,
      OP_MHI   = 6'h0f
   } opcode_e;

endpackage

`default_nettype wire

//--- hw/ncpu_regfile.sv
// Register file with two registered read ports, one write port and write bypass
`default_nettype none

module ncpu_regfile #(
   parameter int DW = 32
) (
   input  wire                clk,
   input  wire                arst_n_i,
   input  wire                rs1_re_i,
   input  ncpu_pkg::reg_addr_t rs1_addr_i,
   input  wire                rs2_re_i,
   input  ncpu_pkg::reg_addr_t rs2_addr_i,
   output logic [DW-1:0]      rs1_data_o,
   output logic [DW-1:0]      rs2_data_o,
   output logic               rs1_valid_o,
   output logic               rs2_valid_o,
   input  wire                we_i,
   input  ncpu_pkg::reg_addr_t waddr_i,
   input  wire  [DW-1:0]      wdata_i
);

   import ncpu_pkg::*;

   logic [DW-1:0] regs_q [NUM_REGS];

   logic          wr_en;
   logic [DW-1:0] rd1_val;
   logic [DW-1:0] rd2_val;

   // r0 is hardwired to zero, writes to it are dropped
   assign wr_en = we_i & (waddr_i != '0);

   // Same-cycle write is forwarded to the reader
   assign rd1_val = (rs1_addr_i == '0) ? '0 :
                    (wr_en && waddr_i == rs1_addr_i) ? wdata_i : regs_q[rs1_addr_i];
   assign rd2_val = (rs2_addr_i == '0) ? '0 :
                    (wr_en && waddr_i == rs2_addr_i) ? wdata_i : regs_q[rs2_addr_i];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en) begin
         regs_q[waddr_i] <= wdata_i;
      end
   end

   // Read data holds until the next read on the same port
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rs1_data_o  <= '0;
         rs2_data_o  <= '0;
         rs1_valid_o <= 1'b0;
         rs2_valid_o <= 1'b0;
      end else begin
         if (rs1_re_i) begin
            rs1_data_o  <= rd1_val;
            rs1_valid_o <= 1'b1;
         end
         if (rs2_re_i) begin
            rs2_data_o  <= rd2_val;
            rs2_valid_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- nano_core.f
hw/ncpu_pkg.sv
hw/ncpu_pipe_buf.sv
hw/ncpu_regfile.sv
hw/ncpu_idu.sv
hw/ncpu_ieu.sv
hw/ncpu_core.sv
verif/ncpu_core_tb.sv

//--- run.sh
#!/bin/sh
# Compile the core slice testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary \
   -f nano_core.f \
   --top-module ncpu_core_tb \
   -Mdir obj_dir \
   -o ncpu_core_sim

# Exit status of the simulation is the result of the run
./obj_dir/ncpu_core_sim

//--- verif/nano_core_trace.txt
// Instruction record: 1 pc word 0 0 0
// Expected record:    2 pc wb rd data emu
1 00000100 1234504f 0 0 0
2 00000100 1 01 48d14000 0
1 00000101 aaf00084 0 0 0
2 00000101 1 02 00002abc 0
1 00000102 000810cb 0 0 0
2 00000102 1 03 48d16abc 0
1 00000103 fff0310c 0 0 0
2 00000103 1 04 48d16ab8 0
1 00000104 0004214d 0 0 0
2 00000104 1 05 b72eeabc 0
1 00000105 ffc05182 0 0 0
2 00000105 1 06 b72eeab0 0
1 00000106 800021c6 0 0 0
2 00000106 1 07 ffffcabc 0
1 00000107 00202208 0 0 0
2 00000107 1 08 002abc00 0
1 00000108 00081249 0 0 0
2 00000108 1 09 00000004 0
1 00000109 00243287 0 0 0
2 00000109 1 0a 8d16abc0 0
1 0000010a 0040a2ca 0 0 0
2 0000010a 1 0b 00008d16 0
1 0000010b 001ca301 0 0 0
2 0000010b 1 0c 8d168a80 0
1 0000010c 000410ce 0 0 0
2 0000010c 0 03 00000001 0
1 0000010d 000010bf 0 0 0
2 0000010d 0 02 00000000 1
1 0000010e 00081003 0 0 0
2 0000010e 1 00 48d16abc 0
1 0000010f 00003345 0 0 0
2 0000010f 1 0d 48d16abc 0
1 00000110 0008d38b 0 0 0
2 00000110 1 0e 48d19578 0

//--- verif/ncpu_core_tb.sv
// Core slice testbench driving a trace with random input gaps and result back-pressure
`default_nettype none

module ncpu_core_tb;

   import ncpu_pkg::*;

   localparam int DW              = 32;
   localparam int AW              = 32;
   localparam int CLK_PERIOD      = 100;
   localparam int DRIVE_DELAY     = 10;
   localparam int RESET_CYCLES    = 3;
   localparam int TRACE_DEPTH     = 512;
   localparam int REC_W           = 6;
   localparam int CYCLES_PER_INSN = 40;
   localparam int DRAIN_CYCLES    = 10;

   // Record kinds in the first column of the trace
   localparam logic [31:0] REC_INSN = 32'd1;
   localparam logic [31:0] REC_EXP  = 32'd2;

   logic          clk;
   logic          arst_n_i;
   logic          insn_valid_i;
   logic          insn_ready_o;
   insn_t         insn_i;
   logic [AW-3:0] insn_pc_i;
   logic          res_valid_o;
   logic          res_ready_i;
   logic [AW-3:0] res_pc_o;
   logic          res_wb_o;
   reg_addr_t     res_addr_o;
   logic [DW-1:0] res_data_o;
   logic          res_emu_o;

   logic [31:0]   trace_mem [TRACE_DEPTH];
   insn_t         insn_word_q [$];
   logic [AW-3:0] insn_pc_q [$];
   logic [AW-3:0] exp_pc_q [$];
   logic          exp_wb_q [$];
   reg_addr_t     exp_addr_q [$];
   logic [DW-1:0] exp_data_q [$];
   logic          exp_emu_q [$];

   logic          trace_ready;
   logic          reset_done;
   time           watchdog_limit;

   ncpu_core #(.DW(DW), .AW(AW)) ncpu_core_i (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .insn_valid_i (insn_valid_i),
      .insn_ready_o (insn_ready_o),
      .insn_i       (insn_i),
      .insn_pc_i    (insn_pc_i),
      .res_valid_o  (res_valid_o),
      .res_ready_i  (res_ready_i),
      .res_pc_o     (res_pc_o),
      .res_wb_o     (res_wb_o),
      .res_addr_o   (res_addr_o),
      .res_data_o   (res_data_o),
      .res_emu_o    (res_emu_o)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_with_failure(input string reason);
      $display("Test failed");
      $fatal(1, "%s", reason);
   endtask

   task automatic compare_value(input string what, input logic [63:0] actual,
                                input logic [63:0] expected);
      if (actual !== expected) begin
         $display("Mismatch at time %0t: %s expected %h got %h",
                  $time, what, expected, actual);
         stop_with_failure($sformatf("%s does not match the trace", what));
      end
   endtask

   // Split the flat trace memory into instruction and expected-result queues
   task automatic load_trace();
      int          base;
      logic [31:0] kind;
      for (int a = 0; a < TRACE_DEPTH; a++) begin
         trace_mem[a] = '0;
      end
      $readmemh("verif/nano_core_trace.txt", trace_mem);
      base = 0;
      while ((base + REC_W <= TRACE_DEPTH) && (trace_mem[base] != '0)) begin
         kind = trace_mem[base];
         if (kind == REC_INSN) begin
            insn_pc_q.push_back(trace_mem[base + 1][AW-3:0]);
            insn_word_q.push_back(trace_mem[base + 2]);
         end else if (kind == REC_EXP) begin
            exp_pc_q.push_back(trace_mem[base + 1][AW-3:0]);
            exp_wb_q.push_back(trace_mem[base + 2][0]);
            exp_addr_q.push_back(trace_mem[base + 3][REG_AW-1:0]);
            exp_data_q.push_back(trace_mem[base + 4][DW-1:0]);
            exp_emu_q.push_back(trace_mem[base + 5][0]);
         end else begin
            stop_with_failure($sformatf("Unknown record kind %0d in the trace file", kind));
         end
         base += REC_W;
      end
   endtask

   // Transfer happens on the rising edge after ready is seen at the falling edge
   task automatic wait_for_accept();
      @(negedge clk);
      while (!insn_ready_o) begin
         @(negedge clk);
      end
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic check_result(input int idx);
      compare_value($sformatf("pc of result %0d", idx),
                    64'(res_pc_o), 64'(exp_pc_q[idx]));
      compare_value($sformatf("wb of result %0d", idx),
                    64'(res_wb_o), 64'(exp_wb_q[idx]));
      compare_value($sformatf("rd of result %0d", idx),
                    64'(res_addr_o), 64'(exp_addr_q[idx]));
      compare_value($sformatf("data of result %0d", idx),
                    64'(res_data_o), 64'(exp_data_q[idx]));
      compare_value($sformatf("emu of result %0d", idx),
                    64'(res_emu_o), 64'(exp_emu_q[idx]));
   endtask

   initial begin : main_sequence
      arst_n_i     = 1'b1;
      insn_valid_i = 1'b0;
      insn_i       = '0;
      insn_pc_i    = '0;
      res_ready_i  = 1'b0;
      trace_ready  = 1'b0;
      reset_done   = 1'b0;
      void'($urandom(32'h2e1));
      load_trace();
      if ((insn_word_q.size() == 0) || (insn_word_q.size() != exp_pc_q.size())) begin
         stop_with_failure($sformatf("Trace holds %0d instructions and %0d expected results",
                                     insn_word_q.size(), exp_pc_q.size()));
      end
      watchdog_limit = 64'(CLK_PERIOD * (insn_word_q.size() * CYCLES_PER_INSN +
                                         RESET_CYCLES + DRAIN_CYCLES));
      trace_ready = 1'b1;
      // Falling edge on reset before the first clock
      #DRIVE_DELAY;
      arst_n_i = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      compare_value("insn_ready_o in reset", 64'(insn_ready_o), 64'd1);
      compare_value("res_valid_o in reset", 64'(res_valid_o), 64'd0);
      #DRIVE_DELAY;
      arst_n_i   = 1'b1;
      reset_done = 1'b1;
   end

   initial begin : instruction_driver
      int gap;
      wait (reset_done);
      for (int i = 0; i < insn_word_q.size(); i++) begin
         // Half of the words go back to back
         gap = (($urandom % 2) == 0) ? 0 : int'($urandom % 3) + 1;
         if (gap != 0) begin
            insn_valid_i = 1'b0;
            repeat (gap) begin
               @(posedge clk);
               #DRIVE_DELAY;
            end
         end
         insn_valid_i = 1'b1;
         insn_i       = insn_word_q[i];
         insn_pc_i    = insn_pc_q[i];
         wait_for_accept();
      end
      insn_valid_i = 1'b0;
   end

   initial begin : result_ready_toggle
      wait (reset_done);
      forever begin
         res_ready_i = (($urandom % 3) != 0);
         @(posedge clk);
         #DRIVE_DELAY;
      end
   end

   initial begin : result_monitor
      int k;
      wait (reset_done);
      k = 0;
      while (k < exp_pc_q.size()) begin
         @(negedge clk);
         if (res_valid_o && res_ready_i) begin
            check_result(k);
            k++;
         end
      end
      // No result may follow the last expected one
      repeat (DRAIN_CYCLES) begin
         @(negedge clk);
         compare_value("res_valid_o after the last result", 64'(res_valid_o), 64'd0);
      end
      $display("Test completed successfully");
      $finish;
   end

   initial begin : watchdog
      wait (trace_ready);
      #(watchdog_limit);
      stop_with_failure("Watchdog timeout, not all expected results arrived in time");
   end

endmodule

`default_nettype wire
